// ==== dv/tb_pr_stream_top.sv ====
// Self-checking testbench for pr_stream_top; drives commands, stalls and shutdown windows
`timescale 1ns/1ps

module tb_pr_stream_top
	import pr_stream_pkg::*;
();

	localparam int N_CMDS          = 48;
	localparam int WATCHDOG_CYCLES = N_CMDS * 40 + 2000;

	logic        clk;
	logic        rst_n;
	logic        cmd_valid;
	pkt_cmd_t    cmd;
	logic        cmd_ready;
	logic        shutdown_req;
	logic        shutdown_ack;
	logic        res_valid;
	pkt_result_t res;
	logic        res_ready;

	integer           seed = 32'h8967;
	pkt_cmd_t         pend_q[$];	// Accepted commands awaiting a result
	int               pend_cnt;
	int               cmd_count;
	int               res_count;
	logic [LEN_W-1:0] exp_len;
	logic [SUM_W-1:0] exp_sum;
	logic             stall_mode;	// Random res_ready stalls
	logic             windows_on;	// Random shutdown windows

	pr_stream_top u_pr_stream_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.cmd_valid    (cmd_valid),
		.cmd          (cmd),
		.cmd_ready    (cmd_ready),
		.shutdown_req (shutdown_req),
		.shutdown_ack (shutdown_ack),
		.res_valid    (res_valid),
		.res          (res),
		.res_ready    (res_ready)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic abort_run();
		$display("Simulation FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	// Words are seed, seed+1, ... each 16 bits, summed modulo 2^24
	function automatic logic [SUM_W-1:0] packet_sum(input pkt_cmd_t c);
		logic [SUM_W-1:0]  acc;
		logic [DATA_W-1:0] w;
		int                i;
		acc = '0;
		w   = c.seed;
		for (i = 0; i < int'(c.len); i++) begin
			acc = acc + SUM_W'(w);
			w   = w + 1'b1;
		end
		return acc;
	endfunction

	// --------------------
	// Reference model
	// --------------------

	always @(posedge clk) begin
		if (rst_n && cmd_valid && cmd_ready) begin
			pend_q.push_back(cmd);
			cmd_count <= cmd_count + 1;
		end
		if (rst_n && res_valid && res_ready && pend_q.size() > 0) begin
			void'(pend_q.pop_front());
			res_count <= res_count + 1;
		end
		if (pend_q.size() > 0) begin
			exp_len <= pend_q[0].len;
			exp_sum <= packet_sum(pend_q[0]);
		end
		pend_cnt <= pend_q.size();
	end

	// --------------------
	// Checks
	// --------------------

	a_reset_state: assert property (@(posedge clk)
		!rst_n |=> !res_valid && !shutdown_ack && cmd_ready)
		else begin
			$display("ERROR %0t res_valid,shutdown_ack,cmd_ready expected 001 actual %b%b%b",
				$time, $sampled(res_valid), $sampled(shutdown_ack), $sampled(cmd_ready));
			abort_run();
		end

	a_res_has_cmd: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid |-> pend_cnt != 0)
		else begin
			$display("Result offered at %0t with no outstanding command", $time);
			abort_run();
		end

	a_res_len: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid |-> res.len == exp_len)
		else begin
			$display("ERROR %0t res.len expected %0d actual %0d",
				$time, $sampled(exp_len), $sampled(res.len));
			abort_run();
		end

	a_res_sum: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid |-> res.sum == exp_sum)
		else begin
			$display("ERROR %0t res.sum expected 0x%06h actual 0x%06h",
				$time, $sampled(exp_sum), $sampled(res.sum));
			abort_run();
		end

	// Stalled result must wait unchanged
	a_res_hold: assert property (@(posedge clk) disable iff (!rst_n)
		res_valid && !res_ready |=> res_valid && $stable(res))
		else begin
			$display("Result changed or dropped at %0t while res_ready was low", $time);
			abort_run();
		end

	a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(shutdown_ack) |-> $past(shutdown_req))
		else begin
			$display("shutdown_ack rose at %0t without a shutdown request", $time);
			abort_run();
		end

	a_ack_holds: assert property (@(posedge clk) disable iff (!rst_n)
		shutdown_ack && shutdown_req |=> shutdown_ack)
		else begin
			$display("shutdown_ack dropped at %0t while shutdown_req was still high", $time);
			abort_run();
		end

	a_ack_release: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(shutdown_req) |=> !shutdown_ack)
		else begin
			$display("shutdown_ack still high at %0t after shutdown_req fell", $time);
			abort_run();
		end

	// --------------------
	// Stimulus
	// --------------------

	always @(negedge clk) begin
		res_ready = stall_mode ? ($unsigned($random(seed)) % 3 != 0) : 1'b1;
	end

	task automatic send_cmd(input pkt_cmd_t c);
		@(negedge clk);
		cmd_valid = 1'b1;
		cmd       = c;
		while (!cmd_ready)
			@(negedge clk);	// cmd_ready only moves at posedge
		@(negedge clk);
		cmd_valid = 1'b0;
	endtask

	task automatic send_random_cmds(input int n);
		pkt_cmd_t c;
		int       k;
		for (k = 0; k < n; k++) begin
			c.seed = DATA_W'($random(seed));
			if (k % 4 == 0)
				c.seed[DATA_W-1:4] = '1;	// Near the top so words wrap
			c.len = LEN_W'(($unsigned($random(seed)) % 16) + 1);
			send_cmd(c);
			repeat ($unsigned($random(seed)) % 3) @(negedge clk);
		end
	endtask

	task automatic shutdown_windows();
		int gap;
		int hold;
		while (windows_on) begin
			gap  = $unsigned($random(seed)) % 20;
			hold = 1 + $unsigned($random(seed)) % 24;
			repeat (gap) @(negedge clk);
			shutdown_req = 1'b1;
			repeat (hold) @(negedge clk);
			shutdown_req = 1'b0;
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired with %0d of %0d results received", res_count, N_CMDS);
		abort_run();
	end

	initial begin
		rst_n        = 1'b0;
		cmd_valid    = 1'b0;
		cmd          = '0;
		shutdown_req = 1'b0;
		res_ready    = 1'b0;
		stall_mode   = 1'b0;
		windows_on   = 1'b0;
		pend_cnt     = 0;
		cmd_count    = 0;
		res_count    = 0;
		exp_len      = '0;
		exp_sum      = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		send_random_cmds(12);	// Free flowing
		stall_mode = 1'b1;
		send_random_cmds(8);	// Result back-pressure

		windows_on = 1'b1;	// Shutdown at random points
		fork
			begin
				send_random_cmds(24);
				windows_on = 1'b0;
			end
			shutdown_windows();
		join
		repeat (4) @(negedge clk);

		// Close the gate, queue commands behind it, then reopen
		shutdown_req = 1'b1;
		while (!shutdown_ack)
			@(negedge clk);
		fork
			send_random_cmds(4);
			begin
				repeat (30) @(negedge clk);
				shutdown_req = 1'b0;
			end
		join

		while (res_count != N_CMDS)
			@(negedge clk);
		repeat (5) @(negedge clk);
		if (res_count == N_CMDS && cmd_count == N_CMDS && pend_q.size() == 0) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			$display("Result count %0d does not match command count %0d", res_count, cmd_count);
			abort_run();
		end
	end

endmodule

// ==== hdl/pkt_source.sv ====
// Packet generator; turns each accepted (seed, len) command into len incrementing stream words
`timescale 1ns/1ps

module pkt_source
	import pr_stream_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,

	input  logic         cmd_valid,
	input  pkt_cmd_t     cmd,
	output logic         cmd_ready,

	output logic         out_valid,
	output stream_beat_t out_beat,
	input  logic         out_ready
);

	src_state_t        state;
	logic [DATA_W-1:0] word;	// Current word value
	logic [LEN_W-1:0]  remain;	// Words left including the current one
	logic              beat_done;

	assign beat_done = out_valid & out_ready;

	// --------------------
	// Control
	// --------------------

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state  <= SRC_IDLE;
			remain <= '0;
		end else begin
			case (state)
				SRC_IDLE: begin
					if (cmd_valid) begin
						state  <= SRC_SEND;
						remain <= cmd.len;
					end
				end
				SRC_SEND: begin
					if (beat_done) begin
						remain <= remain - 1'b1;
						if (out_beat.last)
							state <= SRC_IDLE;	// Packet finished
					end
				end
				default: state <= SRC_IDLE;
			endcase
		end
	end

	// Word value, seed first then +1 per transfer
	always_ff @(posedge clk) begin
		if (state == SRC_IDLE && cmd_valid)
			word <= cmd.seed;
		else if (beat_done)
			word <= word + 1'b1;	// Wraps at 2^16
	end

	assign cmd_ready     = (state == SRC_IDLE);
	assign out_valid     = (state == SRC_SEND);
	assign out_beat.data = word;
	assign out_beat.last = (remain == LEN_W'(1));

	// A stalled beat must not change before it is taken
	a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_beat));

endmodule

// ==== hdl/pkt_summer.sv ====
// Packet reducer; sums the words of each packet and offers one (len, sum) result per packet
`timescale 1ns/1ps

module pkt_summer
	import pr_stream_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,

	input  logic         in_valid,
	input  stream_beat_t in_beat,
	output logic         in_ready,

	output logic         res_valid,
	output pkt_result_t  res,
	input  logic         res_ready
);

	logic [SUM_W-1:0] sum_acc;	// Running sum of current packet
	logic [LEN_W-1:0] cnt_acc;	// Words seen so far
	logic [SUM_W-1:0] sum_next;
	logic [LEN_W-1:0] cnt_next;
	logic             in_xfer;

	assign in_xfer  = in_valid & in_ready;
	assign sum_next = sum_acc + SUM_W'(in_beat.data);
	assign cnt_next = cnt_acc + 1'b1;

	// --------------------
	// Accumulate
	// --------------------

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sum_acc   <= '0;
			cnt_acc   <= '0;
			res_valid <= 1'b0;
		end else begin
			if (in_xfer) begin
				if (in_beat.last) begin
					sum_acc   <= '0;	// Start fresh for the next packet
					cnt_acc   <= '0;
					res_valid <= 1'b1;
				end else begin
					sum_acc <= sum_next;
					cnt_acc <= cnt_next;
				end
			end else if (res_valid && res_ready) begin
				res_valid <= 1'b0;
			end
		end
	end

	// Result capture on the closing word
	always_ff @(posedge clk) begin
		if (in_xfer && in_beat.last) begin
			res.len <= cnt_next;
			res.sum <= sum_next;
		end
	end

	assign in_ready = ~res_valid;	// One result in flight

endmodule

// ==== hdl/pr_shutdown_gate.sv ====
// Stream isolation gate for a reconfigurable region; closes between packets on shutdown_req
`timescale 1ns/1ps

module pr_shutdown_gate
	import pr_stream_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,

	input  logic         shutdown_req,
	output logic         shutdown_ack,

	input  logic         in_valid,
	input  stream_beat_t in_beat,
	output logic         in_ready,

	output logic         out_valid,
	output stream_beat_t out_beat,
	input  logic         out_ready
);

	logic shutdown;	// Gate closed
	logic in_progress;	// Packet started upstream but not finished
	logic in_xfer;

	assign in_xfer = in_valid & in_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			shutdown     <= 1'b0;
			shutdown_ack <= 1'b0;
			in_progress  <= 1'b0;
		end else begin
			shutdown_ack <= shutdown & shutdown_req;	// Never acknowledge a dropped request

			if (in_xfer)
				in_progress <= ~in_beat.last;

			// Close at a boundary, reopen once the request is gone
			if (shutdown_req)
				shutdown <= shutdown | (~in_progress & ~in_xfer) | (in_xfer & in_beat.last);
			else
				shutdown <= 1'b0;
		end
	end

	// --------------------
	// Data path
	// --------------------

	always_comb begin
		if (!shutdown) begin
			out_beat  = in_beat;
			out_valid = in_valid;
			in_ready  = out_ready;
		end else begin
			out_beat  = '0;	// Isolated, drive idle both ways
			out_valid = 1'b0;
			in_ready  = 1'b0;
		end
	end

	// Acknowledge promises a quiet downstream side
	a_idle_when_acked: assert property (@(posedge clk) disable iff (!rst_n)
		shutdown_ack |-> !out_valid);

endmodule

// ==== hdl/pr_stream_pkg.sv ====
// Shared stream types and sizes; modules pull them in with a wildcard import in their header
package pr_stream_pkg;

	// --------------------
	// Sizing
	// --------------------

	localparam int DATA_W     = 16;	// Stream word width
	localparam int LEN_W      = 5;	// Packet length, 1 to 16 words
	localparam int SUM_W      = 24;	// Result sum, wraps at 2^24
	localparam int FIFO_DEPTH = 8;	// Default buffer entries

	// --------------------
	// Payload structs
	// --------------------

	// One beat on any stream link
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic              last;	// Final word of a packet
	} stream_beat_t;

	// Packet request from the command port
	typedef struct packed {
		logic [DATA_W-1:0] seed;	// Value of the first word
		logic [LEN_W-1:0]  len;	// Word count
	} pkt_cmd_t;

	// Per-packet summary on the result port
	typedef struct packed {
		logic [LEN_W-1:0] len;
		logic [SUM_W-1:0] sum;
	} pkt_result_t;

	// --------------------
	// FSM states
	// --------------------

	typedef enum logic {
		SRC_IDLE,	// Waiting for a command
		SRC_SEND	// Emitting packet words
	} src_state_t;

endpackage

// ==== hdl/pr_stream_top.sv ====
// Subsystem top; command port in, packet source through isolation gate and FIFO to summer
`timescale 1ns/1ps

module pr_stream_top
	import pr_stream_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,

	input  logic        cmd_valid,
	input  pkt_cmd_t    cmd,
	output logic        cmd_ready,

	input  logic        shutdown_req,
	output logic        shutdown_ack,

	output logic        res_valid,
	output pkt_result_t res,
	input  logic        res_ready
);

	// --------------------
	// Inter-stage links
	// --------------------

	logic         src_valid;	// Source to gate
	stream_beat_t src_beat;
	logic         src_ready;
	logic         gate_valid;	// Gate to FIFO
	stream_beat_t gate_beat;
	logic         gate_ready;
	logic         buf_valid;	// FIFO to summer
	stream_beat_t buf_beat;
	logic         buf_ready;

	pkt_source u_pkt_source (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.cmd_ready (cmd_ready),
		.out_valid (src_valid),
		.out_beat  (src_beat),
		.out_ready (src_ready)
	);

	pr_shutdown_gate u_pr_shutdown_gate (
		.clk          (clk),
		.rst_n        (rst_n),
		.shutdown_req (shutdown_req),
		.shutdown_ack (shutdown_ack),
		.in_valid     (src_valid),
		.in_beat      (src_beat),
		.in_ready     (src_ready),
		.out_valid    (gate_valid),
		.out_beat     (gate_beat),
		.out_ready    (gate_ready)
	);

	stream_fifo #(
		.DEPTH (FIFO_DEPTH)
	) u_stream_fifo (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (gate_valid),
		.in_beat   (gate_beat),
		.in_ready  (gate_ready),
		.out_valid (buf_valid),
		.out_beat  (buf_beat),
		.out_ready (buf_ready)
	);

	pkt_summer u_pkt_summer (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (buf_valid),
		.in_beat   (buf_beat),
		.in_ready  (buf_ready),
		.res_valid (res_valid),
		.res       (res),
		.res_ready (res_ready)
	);

endmodule

// ==== hdl/stream_fifo.sv ====
// Synchronous beat FIFO with valid/ready on both sides; DEPTH may be any value from 1 up
`timescale 1ns/1ps

module stream_fifo
	import pr_stream_pkg::*;
#(
	parameter int DEPTH = FIFO_DEPTH
)
(
	input  logic         clk,
	input  logic         rst_n,

	input  logic         in_valid,
	input  stream_beat_t in_beat,
	output logic         in_ready,

	output logic         out_valid,
	output stream_beat_t out_beat,
	input  logic         out_ready
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	stream_beat_t     mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;	// Occupancy
	logic             wr_en;
	logic             rd_en;

	assign wr_en = in_valid & in_ready;
	assign rd_en = out_valid & out_ready;

	// --------------------
	// Pointers and count
	// --------------------

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			if (wr_en && !rd_en)
				count <= count + 1'b1;
			else if (rd_en && !wr_en)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= in_beat;
	end

	assign in_ready  = (count != CNT_W'(DEPTH));
	assign out_valid = (count != '0);
	assign out_beat  = mem[rd_ptr];

	// A write never lands on an unread entry
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		wr_en && count != '0 |-> wr_ptr != rd_ptr);
	// A read never catches up with the write pointer
	a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
		rd_en && count != CNT_W'(DEPTH) |-> rd_ptr != wr_ptr);

endmodule

// ==== pr_stream_top.f ====
hdl/pr_stream_pkg.sv
hdl/pkt_source.sv
hdl/pr_shutdown_gate.sv
hdl/stream_fifo.sv
hdl/pkt_summer.sv
hdl/pr_stream_top.sv
dv/tb_pr_stream_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module tb_pr_stream_top \
	-f pr_stream_top.f \
	-Mdir obj_dir \
	&& ./obj_dir/Vtb_pr_stream_top | tee /dev/stderr | grep -F "Simulation PASSED" > /dev/null \
	&& echo "Verilator run OK" \
	|| { echo "Verilator run failed"; exit 1; }

exit 0
